/* Makefile */
# Verilator build and run for the reorder buffer testbench
VERILATOR ?= verilator
TOP       ?= rob_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard logic/*.sv tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail, so the simulator's own status is ignored here
run: compile
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
logic/core_cfg_pkg.sv
logic/rob_types_pkg.sv
logic/rob_queue.sv
logic/branch_check.sv
logic/commit_format.sv
logic/retire_ctrl.sv
logic/rob_top.sv
tests/rob_tb.sv

/* logic/branch_check.sv */
// Head jump checker: compares the resolved target against the fall-through address
`timescale 1ns/1ns

module branch_check
  import core_cfg_pkg::*;
  import rob_types_pkg::*;
(
  input  rob_entry_t    i_head,
  input  logic          i_head_valid,
  output jump_verdict_e o_verdict,
  output redirect_t     o_redirect
);

  logic [XLEN-1:0] fall_through;
  logic            jump_ready;

  assign fall_through = i_head.addr + XLEN'(4);

  // Only a resolved jump at a live head gets a verdict
  assign jump_ready = i_head_valid
                   && (i_head.status == ST_COMPLETED)
                   && i_head.flags.jumps;

  always_comb begin
    o_verdict         = JV_NONE;
    o_redirect.target = '0;
    if (jump_ready) begin
      if (i_head.target == fall_through) begin
        o_verdict = JV_CONFIRMED;
      end else begin
        o_verdict         = JV_MISPREDICTED;
        o_redirect.target = i_head.target;
      end
    end
  end

endmodule

/* logic/commit_format.sv */
// Commit record builder for the head entry, with retire and discard flags
`timescale 1ns/1ns

module commit_format
  import rob_types_pkg::*;
(
  input  rob_entry_t  i_head,
  output commit_rec_t o_commit,
  output logic        o_retirable,
  output logic        o_discard
);

  // Register and memory write enables follow the instruction flags
  always_comb begin
    o_commit.arch_reg  = i_head.regs.arch_reg;
    o_commit.ren_reg   = i_head.regs.ren_reg;
    o_commit.result    = i_head.result;
    o_commit.reg_write = i_head.flags.writes;
    o_commit.mem_write = i_head.flags.mem & i_head.flags.writes;
  end

  // Queue shows an empty head as waiting, so status alone is enough here
  assign o_retirable = (i_head.status == ST_COMPLETED);
  assign o_discard   = (i_head.status == ST_IGNORED);

endmodule

/* logic/core_cfg_pkg.sv */
// Core configuration: reorder buffer depth and datapath widths
package core_cfg_pkg;

  // Reorder buffer depth, must stay a power of two for pointer wrap
  localparam int ROB_SIZE = 16;

  // Width of an entry index, log2 of ROB_SIZE
  localparam int ROB_IDX_W = 4;

  // Data and address width
  localparam int XLEN = 32;

  // Architectural and rename register number width
  localparam int PREG_W = 6;

endpackage

/* logic/retire_ctrl.sv */
// Retire controller: pop, flush and confirm decisions plus registered commit and redirect
`timescale 1ns/1ns

module retire_ctrl
  import rob_types_pkg::*;
(
  input  logic          cs,
  input  logic          i_rst_n,
  input  jump_verdict_e i_verdict,
  input  redirect_t     i_redirect,
  input  commit_rec_t   i_commit,
  input  logic          i_retirable,
  input  logic          i_discard,
  output logic          o_pop,
  output logic          o_flush,
  output logic          o_confirm,
  output logic          o_commit_valid,
  output commit_rec_t   o_commit,
  output logic          o_redirect_valid,
  output redirect_t     o_redirect
);

  // One head leaves per cycle, committed or silently dropped
  assign o_pop = i_retirable | i_discard;

  // Verdict is none unless the head is a completed jump
  assign o_flush   = i_retirable && (i_verdict == JV_MISPREDICTED);
  assign o_confirm = i_retirable && (i_verdict == JV_CONFIRMED);

  always_ff @(posedge cs or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_commit_valid   <= 1'b0;
      o_redirect_valid <= 1'b0;
    end else begin
      o_commit_valid   <= i_retirable;
      o_redirect_valid <= o_flush;
    end
  end

  // Payload holds its last value between strobes
  always_ff @(posedge cs) begin
    if (i_retirable) begin
      o_commit <= i_commit;
    end
    if (o_flush) begin
      o_redirect <= i_redirect;
    end
  end

endmodule

/* logic/rob_queue.sv */
// Reorder buffer storage with dual allocation, dual completion and head/tail tracking
`timescale 1ns/1ns

module rob_queue
  import core_cfg_pkg::*;
  import rob_types_pkg::*;
(
  input  logic                 cs,
  input  logic                 i_rst_n,
  input  issue_slot_t          i_issue [2],
  input  result_bus_t          i_result [2],
  input  logic                 i_pop,
  input  logic                 i_flush,
  input  logic                 i_confirm,
  output rob_entry_t           o_head,
  output logic                 o_head_valid,
  output logic [ROB_IDX_W-1:0] o_issue_idx,
  output logic                 o_full
);

  rob_entry_t           entries [ROB_SIZE];
  logic [ROB_IDX_W-1:0] head;
  logic [ROB_IDX_W-1:0] tail;
  logic [ROB_IDX_W:0]   count;
  logic                 do_issue0;
  logic                 do_issue1;
  logic                 do_pop;
  logic [ROB_IDX_W:0]   n_alloc;
  logic [ROB_IDX_W:0]   n_pop;

  // Fresh entry for an issued slot, result fields filled on completion
  function automatic rob_entry_t new_entry(input issue_slot_t slot);
    rob_entry_t e;
    e.addr   = slot.addr;
    e.result = '0;
    e.target = '0;
    e.status = ST_WAITING;
    e.regs   = slot.regs;
    e.flags  = slot.flags;
    return e;
  endfunction

  assign o_head_valid = (count != '0);
  assign o_issue_idx  = tail;
  assign o_full       = (count > (ROB_IDX_W+1)'(ROB_SIZE - 2));

  // Issue is dropped while full or while the speculative path is flushed
  assign do_issue0 = i_issue[0].valid && !o_full && !i_flush;
  assign do_issue1 = do_issue0 && i_issue[1].valid;
  assign do_pop    = i_pop && o_head_valid;

  assign n_alloc = (ROB_IDX_W+1)'(do_issue0) + (ROB_IDX_W+1)'(do_issue1);
  assign n_pop   = (ROB_IDX_W+1)'(do_pop);

  // An empty buffer shows a waiting head so nothing downstream retires stale data
  always_comb begin
    o_head = entries[head];
    if (!o_head_valid) begin
      o_head.status = ST_WAITING;
    end
  end

  always_ff @(posedge cs or negedge i_rst_n) begin
    if (!i_rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (do_pop) begin
        head <= head + ROB_IDX_W'(1);
      end
      if (do_issue1) begin
        tail <= tail + ROB_IDX_W'(2);
      end else if (do_issue0) begin
        tail <= tail + ROB_IDX_W'(1);
      end
      count <= count + n_alloc - n_pop;
    end
  end

  always_ff @(posedge cs) begin
    if (do_issue0) begin
      entries[tail] <= new_entry(i_issue[0]);
    end
    if (do_issue1) begin
      entries[tail + ROB_IDX_W'(1)] <= new_entry(i_issue[1]);
    end

    // Completion by entry index; a squashed entry stays ignored
    for (int b = 0; b < 2; b++) begin
      if (i_result[b].valid && entries[i_result[b].idx].status != ST_IGNORED) begin
        entries[i_result[b].idx].result <= i_result[b].result;
        if (entries[i_result[b].idx].flags.jumps) begin
          entries[i_result[b].idx].target <= i_result[b].target;
        end
        entries[i_result[b].idx].status <= ST_COMPLETED;
      end
    end

    if (i_flush) begin
      foreach (entries[i]) begin
        if (entries[i].flags.spec) begin
          entries[i].status     <= ST_IGNORED;
          entries[i].flags.spec <= 1'b0;
        end
      end
    end else if (i_confirm) begin
      // Speculation resolved, all tags drop
      foreach (entries[i]) begin
        entries[i].flags.spec <= 1'b0;
      end
    end
  end

endmodule

/* logic/rob_top.sv */
// Reorder buffer top: storage, head evaluators and retire controller
`timescale 1ns/1ns

module rob_top
  import core_cfg_pkg::*;
  import rob_types_pkg::*;
(
  input  logic                 cs,
  input  logic                 i_rst_n,
  input  issue_slot_t          i_issue [2],
  input  result_bus_t          i_result [2],
  output logic [ROB_IDX_W-1:0] o_issue_idx,
  output logic                 o_full,
  output logic                 o_commit_valid,
  output commit_rec_t          o_commit,
  output logic                 o_redirect_valid,
  output redirect_t            o_redirect
);

  rob_entry_t    head_entry;
  logic          head_valid;
  jump_verdict_e verdict;
  redirect_t     head_redirect;
  commit_rec_t   head_commit;
  logic          retirable;
  logic          discard;
  logic          pop;
  logic          flush;
  logic          confirm;

  rob_queue u_queue (
    .cs           (cs),
    .i_rst_n      (i_rst_n),
    .i_issue      (i_issue),
    .i_result     (i_result),
    .i_pop        (pop),
    .i_flush      (flush),
    .i_confirm    (confirm),
    .o_head       (head_entry),
    .o_head_valid (head_valid),
    .o_issue_idx  (o_issue_idx),
    .o_full       (o_full)
  );

  // Both evaluators look at the same head in parallel
  branch_check u_branch (
    .i_head       (head_entry),
    .i_head_valid (head_valid),
    .o_verdict    (verdict),
    .o_redirect   (head_redirect)
  );

  commit_format u_format (
    .i_head      (head_entry),
    .o_commit    (head_commit),
    .o_retirable (retirable),
    .o_discard   (discard)
  );

  retire_ctrl u_retire (
    .cs               (cs),
    .i_rst_n          (i_rst_n),
    .i_verdict        (verdict),
    .i_redirect       (head_redirect),
    .i_commit         (head_commit),
    .i_retirable      (retirable),
    .i_discard        (discard),
    .o_pop            (pop),
    .o_flush          (flush),
    .o_confirm        (confirm),
    .o_commit_valid   (o_commit_valid),
    .o_commit         (o_commit),
    .o_redirect_valid (o_redirect_valid),
    .o_redirect       (o_redirect)
  );

endmodule

/* logic/rob_types_pkg.sv */
// Reorder buffer record types: entry, issue, result, commit and redirect
package rob_types_pkg;
  import core_cfg_pkg::*;

  // Lifecycle of one buffer entry
  typedef enum logic [1:0] {
    ST_WAITING,
    ST_COMPLETED,
    ST_IGNORED
  } entry_status_e;

  // Outcome of the jump currently at the head
  typedef enum logic [1:0] {
    JV_NONE,
    JV_CONFIRMED,
    JV_MISPREDICTED
  } jump_verdict_e;

  typedef struct packed {
    logic [PREG_W-1:0] arch_reg;
    logic [PREG_W-1:0] ren_reg;
  } reg_map_t;

  // spec marks instructions issued behind an unresolved jump
  typedef struct packed {
    logic writes;
    logic mem;
    logic jumps;
    logic spec;
  } instr_flags_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] addr;
    reg_map_t        regs;
    instr_flags_t    flags;
  } issue_slot_t;

  typedef struct packed {
    logic                 valid;
    logic [ROB_IDX_W-1:0] idx;
    logic [XLEN-1:0]      result;
    logic [XLEN-1:0]      target;
  } result_bus_t;

  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] target;
    entry_status_e   status;
    reg_map_t        regs;
    instr_flags_t    flags;
  } rob_entry_t;

  typedef struct packed {
    logic [PREG_W-1:0] arch_reg;
    logic [PREG_W-1:0] ren_reg;
    logic [XLEN-1:0]   result;
    logic              reg_write;
    logic              mem_write;
  } commit_rec_t;

  typedef struct packed {
    logic [XLEN-1:0] target;
  } redirect_t;

endpackage

/* tests/rob_tb.sv */
// Reorder buffer testbench with a commit reference model, phased stimulus and a watchdog
`timescale 1ns/1ns

module rob_tb
  import core_cfg_pkg::*;
  import rob_types_pkg::*;
();

  localparam int CLK_PERIOD       = 40;
  localparam int DRIVE_DELAY      = 5;
  localparam int RESET_CYCLES     = 8;
  localparam int RAND_PHASES      = 8;
  localparam int JUMP_PHASES      = 4;
  localparam int PHASE_MAX_CYCLES = 150;
  // Reset, random, flag sweep, confirmed, mispredicted and the two full-buffer phases
  localparam int TOTAL_PHASES     = 1 + RAND_PHASES + 1 + 2 * JUMP_PHASES + 2;
  localparam int WATCHDOG_CYCLES  = RESET_CYCLES + TOTAL_PHASES * PHASE_MAX_CYCLES + 200;

  // One predicted commit and whether a redirect rides with it
  typedef struct packed {
    commit_rec_t     rec;
    logic            redir;
    logic [XLEN-1:0] target;
  } expect_t;

  logic                 cs;
  logic                 i_rst_n;
  issue_slot_t          i_issue [2];
  result_bus_t          i_result [2];
  logic [ROB_IDX_W-1:0] o_issue_idx;
  logic                 o_full;
  logic                 o_commit_valid;
  commit_rec_t          o_commit;
  logic                 o_redirect_valid;
  redirect_t            o_redirect;

  expect_t exp_q [$];
  expect_t exp_item;
  int      errors;
  int      checks;
  int      tests_run;
  int      tests_failed;
  int      test_err_base;

  // Tail index predicted from the number of issued slots
  logic [ROB_IDX_W-1:0] model_tail;

  rob_top uut (
    .cs               (cs),
    .i_rst_n          (i_rst_n),
    .i_issue          (i_issue),
    .i_result         (i_result),
    .o_issue_idx      (o_issue_idx),
    .o_full           (o_full),
    .o_commit_valid   (o_commit_valid),
    .o_commit         (o_commit),
    .o_redirect_valid (o_redirect_valid),
    .o_redirect       (o_redirect)
  );

  initial begin
    cs = 1'b0;
    forever #(CLK_PERIOD / 2) cs = ~cs;
  end

  // Commit record predicted from the issued instruction and its result
  function automatic commit_rec_t expected_commit(input issue_slot_t slot,
                                                  input logic [XLEN-1:0] result);
    commit_rec_t c;
    c.arch_reg  = slot.regs.arch_reg;
    c.ren_reg   = slot.regs.ren_reg;
    c.result    = result;
    c.reg_write = slot.flags.writes;
    // A store only counts when the write flag is also set
    c.mem_write = slot.flags.mem && slot.flags.writes;
    return c;
  endfunction

  task automatic step();
    @(posedge cs);
    #(DRIVE_DELAY);
  endtask

  task automatic report_mismatch(input string sig, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] want);
    $display("mismatch %s: got 0x%0h, expected 0x%0h at %0t", sig, got, want, $time);
    errors++;
  endtask

  task automatic report_error(input string msg);
    $display("error: %s at %0t", msg, $time);
    errors++;
  endtask

  task automatic start_test();
    test_err_base = errors;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors != test_err_base) begin
      tests_failed++;
      $display("test %0d %s: FAILED, %0d errors", tests_run, name, errors - test_err_base);
    end else begin
      $display("test %0d %s: passed", tests_run, name);
    end
  endtask

  // Issue n instructions, optionally hold, return results in random order, then drain
  task automatic run_phase(input int n, input int jpos, input bit mispredict,
                           input bit flag_sweep, input bit fill_check, input int hold);
    issue_slot_t          slots [ROB_SIZE];
    logic [ROB_IDX_W-1:0] idxs [ROB_SIZE];
    logic [XLEN-1:0]      results [ROB_SIZE];
    logic [XLEN-1:0]      targets [ROB_SIZE];
    int                   order [ROB_SIZE];
    expect_t              e;
    int                   k;
    int                   j;
    int                   tmp;
    int                   waited;
    int                   ignored;

    for (int i = 0; i < n; i++) begin
      slots[i].valid         = 1'b1;
      slots[i].addr          = $urandom() & 32'hffff_fffc;
      slots[i].regs.arch_reg = PREG_W'($urandom());
      slots[i].regs.ren_reg  = PREG_W'($urandom());
      slots[i].flags.writes  = flag_sweep ? i[0] : 1'($urandom());
      slots[i].flags.mem     = flag_sweep ? i[1] : 1'($urandom());
      slots[i].flags.jumps   = (i == jpos);
      // Everything behind the jump is speculative
      slots[i].flags.spec    = (jpos >= 0) && (i > jpos);
      results[i] = $urandom();
      targets[i] = $urandom();
      if (i == jpos) begin
        targets[i] = slots[i].addr + XLEN'(4);
        if (mispredict) begin
          targets[i] = targets[i] + XLEN'(4 * $urandom_range(1, 64));
        end
      end
      order[i] = i;
    end

    // Reference: in order, and nothing behind a mispredicted jump
    ignored = 0;
    for (int i = 0; i < n; i++) begin
      if (mispredict && jpos >= 0 && i > jpos) begin
        ignored++;
      end else begin
        e.rec    = expected_commit(slots[i], results[i]);
        e.redir  = mispredict && (i == jpos);
        e.target = targets[i];
        exp_q.push_back(e);
      end
    end

    k = 0;
    while (k < n) begin
      if (fill_check && (o_full !== (k >= ROB_SIZE - 1))) begin
        report_mismatch("o_full", XLEN'(o_full), XLEN'(k >= ROB_SIZE - 1));
      end
      if (o_issue_idx !== model_tail) begin
        report_mismatch("o_issue_idx", XLEN'(o_issue_idx), XLEN'(model_tail));
      end
      i_issue[0] = slots[k];
      i_issue[1] = '0;
      idxs[k]    = model_tail;
      model_tail = model_tail + ROB_IDX_W'(1);
      k++;
      // Single issue while filling, so every occupancy level is seen
      if (k < n && !fill_check && $urandom_range(0, 1) == 1) begin
        i_issue[1] = slots[k];
        idxs[k]    = model_tail;
        model_tail = model_tail + ROB_IDX_W'(1);
        k++;
      end
      step();
    end
    i_issue[0] = '0;
    i_issue[1] = '0;
    if (fill_check && (o_full !== (n >= ROB_SIZE - 1))) begin
      report_mismatch("o_full", XLEN'(o_full), XLEN'(n >= ROB_SIZE - 1));
    end

    repeat (hold) begin
      if (o_commit_valid !== 1'b0 || o_redirect_valid !== 1'b0) begin
        report_error("commit or redirect strobe rose while no result had returned");
      end
      step();
    end

    // Fisher-Yates shuffle of the completion order
    for (int i = n - 1; i > 0; i--) begin
      j        = $urandom_range(0, i);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    k = 0;
    while (k < n) begin
      i_result[0] = '0;
      i_result[1] = '0;
      for (int b = 0; b < 2; b++) begin
        if (k < n && (b == 0 || $urandom_range(0, 1) == 1)) begin
          i_result[b].valid  = 1'b1;
          i_result[b].idx    = idxs[order[k]];
          i_result[b].result = results[order[k]];
          i_result[b].target = targets[order[k]];
          k++;
        end
      end
      step();
    end
    i_result[0] = '0;
    i_result[1] = '0;

    waited = 0;
    while (exp_q.size() != 0 && waited < 4 * n + 20) begin
      step();
      waited++;
    end
    if (exp_q.size() != 0) begin
      report_error($sformatf("%0d expected commits never appeared", exp_q.size()));
      exp_q.delete();
    end
    // Squashed entries leave the head one per cycle after the jump retires
    repeat (ignored + 2) step();
    if (o_full !== 1'b0) begin
      report_mismatch("o_full", XLEN'(o_full), XLEN'(0));
    end
  endtask

  // Compare each commit against the model, sampled away from the driving edge
  always @(negedge cs) begin
    if (i_rst_n && o_redirect_valid && !o_commit_valid) begin
      report_error("redirect strobe appeared without its commit");
    end
    if (i_rst_n && o_commit_valid) begin
      checks++;
      if (exp_q.size() == 0) begin
        report_error("commit strobe with no expected commit pending");
      end else begin
        exp_item = exp_q.pop_front();
        if (o_commit.arch_reg !== exp_item.rec.arch_reg) begin
          report_mismatch("o_commit.arch_reg", XLEN'(o_commit.arch_reg),
                          XLEN'(exp_item.rec.arch_reg));
        end
        if (o_commit.ren_reg !== exp_item.rec.ren_reg) begin
          report_mismatch("o_commit.ren_reg", XLEN'(o_commit.ren_reg),
                          XLEN'(exp_item.rec.ren_reg));
        end
        if (o_commit.result !== exp_item.rec.result) begin
          report_mismatch("o_commit.result", o_commit.result, exp_item.rec.result);
        end
        if (o_commit.reg_write !== exp_item.rec.reg_write) begin
          report_mismatch("o_commit.reg_write", XLEN'(o_commit.reg_write),
                          XLEN'(exp_item.rec.reg_write));
        end
        if (o_commit.mem_write !== exp_item.rec.mem_write) begin
          report_mismatch("o_commit.mem_write", XLEN'(o_commit.mem_write),
                          XLEN'(exp_item.rec.mem_write));
        end
        if (o_redirect_valid !== exp_item.redir) begin
          report_mismatch("o_redirect_valid", XLEN'(o_redirect_valid), XLEN'(exp_item.redir));
        end else if (exp_item.redir && o_redirect.target !== exp_item.target) begin
          report_mismatch("o_redirect.target", o_redirect.target, exp_item.target);
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge cs);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

  initial begin
    int n;
    int jpos;
    void'($urandom(32'h7abf_4c48));
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    model_tail   = '0;
    i_rst_n      = 1'b0;
    i_issue[0]   = '0;
    i_issue[1]   = '0;
    i_result[0]  = '0;
    i_result[1]  = '0;

    start_test();
    repeat (RESET_CYCLES) begin
      @(negedge cs);
      if (o_commit_valid !== 1'b0 || o_redirect_valid !== 1'b0) begin
        report_error("commit or redirect strobe active during reset");
      end
    end
    step();
    i_rst_n = 1'b1;
    run_phase(2, -1, 1'b0, 1'b0, 1'b0, 6);
    finish_test("quiet strobes after reset");

    start_test();
    repeat (RAND_PHASES) begin
      n = $urandom_range(1, 12);
      run_phase(n, -1, 1'b0, 1'b0, 1'b0, 0);
    end
    finish_test("in-order commit");

    start_test();
    run_phase(8, -1, 1'b0, 1'b1, 1'b0, 0);
    finish_test("write flags");

    start_test();
    repeat (JUMP_PHASES) begin
      n    = $urandom_range(3, 12);
      jpos = $urandom_range(0, n - 2);
      run_phase(n, jpos, 1'b0, 1'b0, 1'b0, 0);
    end
    finish_test("confirmed jump");

    start_test();
    repeat (JUMP_PHASES) begin
      n    = $urandom_range(3, 12);
      jpos = $urandom_range(0, n - 2);
      run_phase(n, jpos, 1'b1, 1'b0, 1'b0, 0);
    end
    finish_test("mispredicted jump");

    // Fill to one free entry, drain, then issue again
    start_test();
    run_phase(ROB_SIZE - 1, -1, 1'b0, 1'b0, 1'b1, 0);
    run_phase(4, -1, 1'b0, 1'b0, 1'b0, 0);
    finish_test("full buffer");

    $display("tests run %0d, tests failed %0d, commits checked %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
